//--- source/ao_periph_pkg.sv
/*
 * Always-on peripheral subsystem shared definitions.
 * Bus types, address map and register word offsets.
 */
package ao_periph_pkg;

  // Bus and register types
  typedef logic [31:0] ao_addr_t;
  typedef logic [31:0] ao_data_t;
  typedef logic [9:0]  ao_offset_t;
  typedef logic [2:0]  ao_sel_t;
  typedef logic [19:0] ao_page_t;

  // One-hot select bit positions
  localparam int unsigned SOC_CTRL_IDX  = 0;
  localparam int unsigned FAST_INTR_IDX = 1;
  localparam int unsigned GPIO_IDX      = 2;

  // 4 KiB windows, picked by address bits 31..12
  localparam ao_page_t SOC_CTRL_BASE_PAGE  = 20'h00000;
  localparam ao_page_t FAST_INTR_BASE_PAGE = 20'h00001;
  localparam ao_page_t GPIO_BASE_PAGE      = 20'h00002;

  // SoC control registers
  localparam ao_offset_t SOC_EXIT_VALID_OFS = 10'd0;
  localparam ao_offset_t SOC_EXIT_VALUE_OFS = 10'd1;
  localparam ao_offset_t SOC_BOOT_SEL_OFS   = 10'd2;

  // Fast interrupt controller registers
  localparam ao_offset_t FIC_PENDING_OFS = 10'd0;
  localparam ao_offset_t FIC_ENABLE_OFS  = 10'd1;

  // GPIO registers
  localparam ao_offset_t GPIO_OUT_OFS     = 10'd0;
  localparam ao_offset_t GPIO_EN_OFS      = 10'd1;
  localparam ao_offset_t GPIO_IN_OFS      = 10'd2;
  localparam ao_offset_t GPIO_INTR_EN_OFS = 10'd3;

  // Default peripheral widths, valid from 1 to 32
  localparam int unsigned GPIO_NUM_DEFAULT      = 8;
  localparam int unsigned FAST_INTR_NUM_DEFAULT = 16;

endpackage : ao_periph_pkg

//--- source/ao_periph_decode.sv
/*
 * Always-on bus request decoder.
 * Registers one request and splits it into per-peripheral strobes.
 */
`timescale 1ns/1ps

module ao_periph_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  ao_periph_pkg::ao_addr_t addr_i,
  input  ao_periph_pkg::ao_data_t wdata_i,
  output ao_periph_pkg::ao_sel_t  wr_sel_o,
  output ao_periph_pkg::ao_sel_t  rd_sel_o,
  output ao_periph_pkg::ao_offset_t offset_o,
  output ao_periph_pkg::ao_data_t wdata_o,
  output logic                   rsp_pending_o,
  output logic                   err_o
);

  ao_periph_pkg::ao_page_t   page;
  ao_periph_pkg::ao_sel_t    sel_d;
  ao_periph_pkg::ao_sel_t    sel_q;
  logic                      req_q;
  logic                      we_q;
  logic                      err_q;
  ao_periph_pkg::ao_offset_t offset_q;
  ao_periph_pkg::ao_data_t   wdata_q;

  // Window match on the upper address bits
  assign page = addr_i[31:12];

  always_comb begin
    sel_d = '0;
    sel_d[ao_periph_pkg::SOC_CTRL_IDX]  = (page == ao_periph_pkg::SOC_CTRL_BASE_PAGE);
    sel_d[ao_periph_pkg::FAST_INTR_IDX] = (page == ao_periph_pkg::FAST_INTR_BASE_PAGE);
    sel_d[ao_periph_pkg::GPIO_IDX]      = (page == ao_periph_pkg::GPIO_BASE_PAGE);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
      we_q  <= 1'b0;
      sel_q <= '0;
      err_q <= 1'b0;
    end else begin
      req_q <= req_i;
      we_q  <= we_i;
      sel_q <= req_i ? sel_d : '0;
      // No window hit means an error response
      err_q <= req_i && (sel_d == '0);
    end
  end

  // Payload only follows a live request
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      offset_q <= addr_i[11:2];
      wdata_q  <= wdata_i;
    end
  end

  assign wr_sel_o      = sel_q & {3{req_q & we_q}};
  assign rd_sel_o      = sel_q & {3{req_q & ~we_q}};
  assign offset_o      = offset_q;
  assign wdata_o       = wdata_q;
  assign rsp_pending_o = req_q;
  assign err_o         = err_q;

endmodule : ao_periph_decode

//--- source/soc_ctrl_regs.sv
/*
 * SoC control registers.
 * Exit flag and exit value for the host, boot select status.
 */
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_en_i,
  input  ao_periph_pkg::ao_offset_t offset_i,
  input  ao_periph_pkg::ao_data_t   wdata_i,
  input  logic                      boot_select_i,
  output ao_periph_pkg::ao_data_t   rdata_o,
  output logic                      exit_valid_o,
  output ao_periph_pkg::ao_data_t   exit_value_o
);

  logic                    exit_valid_q;
  ao_periph_pkg::ao_data_t exit_value_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en_i) begin
      if (offset_i == ao_periph_pkg::SOC_EXIT_VALID_OFS) begin
        exit_valid_q <= wdata_i[0];
      end
      if (offset_i == ao_periph_pkg::SOC_EXIT_VALUE_OFS) begin
        exit_value_q <= wdata_i;
      end
    end
  end

  // Read side, unknown offsets give zero
  always_comb begin
    rdata_o = '0;
    case (offset_i)
      ao_periph_pkg::SOC_EXIT_VALID_OFS: begin
        rdata_o[0] = exit_valid_q;
      end
      ao_periph_pkg::SOC_EXIT_VALUE_OFS: begin
        rdata_o = exit_value_q;
      end
      ao_periph_pkg::SOC_BOOT_SEL_OFS: begin
        rdata_o[0] = boot_select_i;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl_regs

//--- source/fast_intr_ctrl.sv
/*
 * Fast interrupt controller.
 * Sticky pending bits with write-one-to-clear and per-line enables.
 */
`timescale 1ns/1ps

module fast_intr_ctrl #(
  parameter int unsigned FAST_INTR_NUM = ao_periph_pkg::FAST_INTR_NUM_DEFAULT
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_en_i,
  input  ao_periph_pkg::ao_offset_t offset_i,
  input  ao_periph_pkg::ao_data_t   wdata_i,
  input  logic [FAST_INTR_NUM-1:0]  fast_intr_i,
  output ao_periph_pkg::ao_data_t   rdata_o,
  output logic [FAST_INTR_NUM-1:0]  fast_intr_o
);

  logic [FAST_INTR_NUM-1:0] pending_q;
  logic [FAST_INTR_NUM-1:0] enable_q;
  logic [FAST_INTR_NUM-1:0] clear;

  // Write-one-to-clear mask on PENDING
  assign clear = (wr_en_i && offset_i == ao_periph_pkg::FIC_PENDING_OFS) ?
                 wdata_i[FAST_INTR_NUM-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // A live input beats a clear in the same cycle
      pending_q <= (pending_q & ~clear) | fast_intr_i;
      if (wr_en_i && offset_i == ao_periph_pkg::FIC_ENABLE_OFS) begin
        enable_q <= wdata_i[FAST_INTR_NUM-1:0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      ao_periph_pkg::FIC_PENDING_OFS: begin
        rdata_o[FAST_INTR_NUM-1:0] = pending_q;
      end
      ao_periph_pkg::FIC_ENABLE_OFS: begin
        rdata_o[FAST_INTR_NUM-1:0] = enable_q;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule : fast_intr_ctrl

//--- source/gpio_ao.sv
/*
 * Always-on GPIO block.
 * Output and output-enable registers, synchronized inputs, level interrupts.
 */
`timescale 1ns/1ps

module gpio_ao #(
  parameter int unsigned GPIO_NUM = ao_periph_pkg::GPIO_NUM_DEFAULT
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_en_i,
  input  ao_periph_pkg::ao_offset_t offset_i,
  input  ao_periph_pkg::ao_data_t   wdata_i,
  input  logic [GPIO_NUM-1:0]       cio_gpio_i,
  output ao_periph_pkg::ao_data_t   rdata_o,
  output logic [GPIO_NUM-1:0]       cio_gpio_o,
  output logic [GPIO_NUM-1:0]       cio_gpio_en_o,
  output logic [GPIO_NUM-1:0]       intr_gpio_o
);

  logic [GPIO_NUM-1:0] out_q;
  logic [GPIO_NUM-1:0] en_q;
  logic [GPIO_NUM-1:0] intr_en_q;
  logic [GPIO_NUM-1:0] in_meta_q;
  logic [GPIO_NUM-1:0] in_sync_q;

  // Software visible registers
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en_i) begin
      case (offset_i)
        ao_periph_pkg::GPIO_OUT_OFS: begin
          out_q <= wdata_i[GPIO_NUM-1:0];
        end
        ao_periph_pkg::GPIO_EN_OFS: begin
          en_q <= wdata_i[GPIO_NUM-1:0];
        end
        ao_periph_pkg::GPIO_INTR_EN_OFS: begin
          intr_en_q <= wdata_i[GPIO_NUM-1:0];
        end
        default: begin
          // IN is read-only
        end
      endcase
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= cio_gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offset_i)
      ao_periph_pkg::GPIO_OUT_OFS:     rdata_o[GPIO_NUM-1:0] = out_q;
      ao_periph_pkg::GPIO_EN_OFS:      rdata_o[GPIO_NUM-1:0] = en_q;
      ao_periph_pkg::GPIO_IN_OFS:      rdata_o[GPIO_NUM-1:0] = in_sync_q;
      ao_periph_pkg::GPIO_INTR_EN_OFS: rdata_o[GPIO_NUM-1:0] = intr_en_q;
      default:                         rdata_o = '0;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = en_q;
  // Level interrupt, held as long as the pin stays high
  assign intr_gpio_o   = in_sync_q & intr_en_q;

endmodule : gpio_ao

//--- source/ao_rsp_mux.sv
/*
 * Bus response stage.
 * Picks the read data of the addressed peripheral and registers the response.
 */
`timescale 1ns/1ps

module ao_rsp_mux (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::ao_sel_t  rd_sel_i,
  input  logic                    rsp_pending_i,
  input  logic                    err_i,
  input  ao_periph_pkg::ao_data_t soc_rdata_i,
  input  ao_periph_pkg::ao_data_t fic_rdata_i,
  input  ao_periph_pkg::ao_data_t gpio_rdata_i,
  output logic                    rsp_valid_o,
  output ao_periph_pkg::ao_data_t rdata_o,
  output logic                    error_o
);

  ao_periph_pkg::ao_data_t rdata_d;
  ao_periph_pkg::ao_data_t rdata_q;
  logic                    rsp_valid_q;
  logic                    error_q;

  // AND-OR select, zero for writes and errors since rd_sel is empty then
  always_comb begin
    rdata_d = '0;
    if (rd_sel_i[ao_periph_pkg::SOC_CTRL_IDX]) begin
      rdata_d = rdata_d | soc_rdata_i;
    end
    if (rd_sel_i[ao_periph_pkg::FAST_INTR_IDX]) begin
      rdata_d = rdata_d | fic_rdata_i;
    end
    if (rd_sel_i[ao_periph_pkg::GPIO_IDX]) begin
      rdata_d = rdata_d | gpio_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      error_q     <= 1'b0;
    end else begin
      rsp_valid_q <= rsp_pending_i;
      error_q     <= err_i;
    end
  end

  always_ff @(posedge clk_i) begin
    rdata_q <= rdata_d;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rdata_o     = rdata_q;
  assign error_o     = error_q;

endmodule : ao_rsp_mux

//--- source/ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem top level.
 * Decoder, SoC control, fast interrupts, GPIO and the response stage.
 */
`timescale 1ns/1ps

module ao_peripheral_subsystem #(
  parameter int unsigned GPIO_NUM      = ao_periph_pkg::GPIO_NUM_DEFAULT,
  parameter int unsigned FAST_INTR_NUM = ao_periph_pkg::FAST_INTR_NUM_DEFAULT
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // System bus, one-cycle request and response
  input  logic                     bus_req_i,
  input  logic                     bus_we_i,
  input  ao_periph_pkg::ao_addr_t  bus_addr_i,
  input  ao_periph_pkg::ao_data_t  bus_wdata_i,
  output logic                     bus_rsp_valid_o,
  output ao_periph_pkg::ao_data_t  bus_rdata_o,
  output logic                     bus_error_o,

  // SoC control
  input  logic                     boot_select_i,
  output logic                     exit_valid_o,
  output ao_periph_pkg::ao_data_t  exit_value_o,

  // Fast interrupts
  input  logic [FAST_INTR_NUM-1:0] fast_intr_i,
  output logic [FAST_INTR_NUM-1:0] fast_intr_o,

  // GPIO
  input  logic [GPIO_NUM-1:0]      cio_gpio_i,
  output logic [GPIO_NUM-1:0]      cio_gpio_o,
  output logic [GPIO_NUM-1:0]      cio_gpio_en_o,
  output logic [GPIO_NUM-1:0]      intr_gpio_o
);

  ao_periph_pkg::ao_sel_t    wr_sel;
  ao_periph_pkg::ao_sel_t    rd_sel;
  ao_periph_pkg::ao_offset_t offset;
  ao_periph_pkg::ao_data_t   wdata;
  logic                      rsp_pending;
  logic                      dec_err;
  ao_periph_pkg::ao_data_t   soc_rdata;
  ao_periph_pkg::ao_data_t   fic_rdata;
  ao_periph_pkg::ao_data_t   gpio_rdata;

  ao_periph_decode ao_periph_decode_i (
    .clk_i,
    .rst_n_i,
    .req_i        (bus_req_i),
    .we_i         (bus_we_i),
    .addr_i       (bus_addr_i),
    .wdata_i      (bus_wdata_i),
    .wr_sel_o     (wr_sel),
    .rd_sel_o     (rd_sel),
    .offset_o     (offset),
    .wdata_o      (wdata),
    .rsp_pending_o(rsp_pending),
    .err_o        (dec_err)
  );

  soc_ctrl_regs soc_ctrl_regs_i (
    .clk_i,
    .rst_n_i,
    .wr_en_i      (wr_sel[ao_periph_pkg::SOC_CTRL_IDX]),
    .offset_i     (offset),
    .wdata_i      (wdata),
    .boot_select_i,
    .rdata_o      (soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl #(
    .FAST_INTR_NUM(FAST_INTR_NUM)
  ) fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .wr_en_i    (wr_sel[ao_periph_pkg::FAST_INTR_IDX]),
    .offset_i   (offset),
    .wdata_i    (wdata),
    .fast_intr_i,
    .rdata_o    (fic_rdata),
    .fast_intr_o
  );

  gpio_ao #(
    .GPIO_NUM(GPIO_NUM)
  ) gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .wr_en_i      (wr_sel[ao_periph_pkg::GPIO_IDX]),
    .offset_i     (offset),
    .wdata_i      (wdata),
    .cio_gpio_i,
    .rdata_o      (gpio_rdata),
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

  ao_rsp_mux ao_rsp_mux_i (
    .clk_i,
    .rst_n_i,
    .rd_sel_i     (rd_sel),
    .rsp_pending_i(rsp_pending),
    .err_i        (dec_err),
    .soc_rdata_i  (soc_rdata),
    .fic_rdata_i  (fic_rdata),
    .gpio_rdata_i (gpio_rdata),
    .rsp_valid_o  (bus_rsp_valid_o),
    .rdata_o      (bus_rdata_o),
    .error_o      (bus_error_o)
  );

endmodule : ao_peripheral_subsystem

//--- test/ao_periph_checker.sv
/*
 * Bus timing and reset assertions for the always-on peripheral subsystem.
 */
`timescale 1ns/1ps

module ao_periph_checker #(
  parameter int unsigned FAST_INTR_NUM = ao_periph_pkg::FAST_INTR_NUM_DEFAULT
) (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     req_i,
  input logic                     rsp_valid_i,
  input ao_periph_pkg::ao_data_t  rdata_i,
  input logic                     error_i,
  input logic                     exit_valid_i,
  input logic [FAST_INTR_NUM-1:0] intr_out_i
);

  int unsigned fail_count = 0;

  // Response strobe trails the request by exactly two edges
  rsp_timing: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i == $past(req_i, 2))
    else begin
      $error("response strobe does not match the request two cycles earlier");
      fail_count++;
    end

  err_no_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    error_i |-> rdata_i == '0)
    else begin
      $error("error response carries nonzero read data");
      fail_count++;
    end

  // Outputs come out of reset cleared
  reset_clear: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !exit_valid_i && intr_out_i == '0)
    else begin
      $error("exit flag or fast interrupt set right after reset");
      fail_count++;
    end

endmodule : ao_periph_checker

bind ao_peripheral_subsystem ao_periph_checker #(
  .FAST_INTR_NUM(FAST_INTR_NUM)
) timing_chk (
  .clk_i,
  .rst_n_i,
  .req_i        (bus_req_i),
  .rsp_valid_i  (bus_rsp_valid_o),
  .rdata_i      (bus_rdata_o),
  .error_i      (bus_error_o),
  .exit_valid_i (exit_valid_o),
  .intr_out_i   (fast_intr_o)
);

//--- test/tb_ao_peripheral_subsystem.sv
/*
 * Testbench for the always-on peripheral subsystem.
 * Random bus traffic and pin stimulus checked against a register model.
 */
`timescale 1ns/1ps

module tb_ao_peripheral_subsystem;

  localparam int GPIO_NUM      = ao_periph_pkg::GPIO_NUM_DEFAULT;
  localparam int FAST_INTR_NUM = ao_periph_pkg::FAST_INTR_NUM_DEFAULT;
  localparam int TOTAL_REQ     = 9 + 200 + 40 + 25 + 18;

  localparam ao_periph_pkg::ao_page_t P_SOC  = ao_periph_pkg::SOC_CTRL_BASE_PAGE;
  localparam ao_periph_pkg::ao_page_t P_FIC  = ao_periph_pkg::FAST_INTR_BASE_PAGE;
  localparam ao_periph_pkg::ao_page_t P_GPIO = ao_periph_pkg::GPIO_BASE_PAGE;

  // Word addresses of every register
  localparam logic [31:0] A_EXIT_VALID = {P_SOC, ao_periph_pkg::SOC_EXIT_VALID_OFS, 2'b00};
  localparam logic [31:0] A_EXIT_VALUE = {P_SOC, ao_periph_pkg::SOC_EXIT_VALUE_OFS, 2'b00};
  localparam logic [31:0] A_BOOT_SEL   = {P_SOC, ao_periph_pkg::SOC_BOOT_SEL_OFS, 2'b00};
  localparam logic [31:0] A_PENDING    = {P_FIC, ao_periph_pkg::FIC_PENDING_OFS, 2'b00};
  localparam logic [31:0] A_ENABLE     = {P_FIC, ao_periph_pkg::FIC_ENABLE_OFS, 2'b00};
  localparam logic [31:0] A_GPIO_OUT   = {P_GPIO, ao_periph_pkg::GPIO_OUT_OFS, 2'b00};
  localparam logic [31:0] A_GPIO_EN    = {P_GPIO, ao_periph_pkg::GPIO_EN_OFS, 2'b00};
  localparam logic [31:0] A_GPIO_IN    = {P_GPIO, ao_periph_pkg::GPIO_IN_OFS, 2'b00};
  localparam logic [31:0] A_INTR_EN    = {P_GPIO, ao_periph_pkg::GPIO_INTR_EN_OFS, 2'b00};
  localparam logic [31:0] TARGETS [9] = '{A_EXIT_VALID, A_EXIT_VALUE, A_BOOT_SEL,
                                          A_PENDING, A_ENABLE, A_GPIO_OUT,
                                          A_GPIO_EN, A_GPIO_IN, A_INTR_EN};

  logic clk_i, rst_n_i, bus_req_i, bus_we_i, boot_select_i;
  logic bus_rsp_valid_o, bus_error_o, exit_valid_o;
  logic [31:0] bus_addr_i, bus_wdata_i, bus_rdata_o, exit_value_o;
  logic [FAST_INTR_NUM-1:0] fast_intr_i, fast_intr_o;
  logic [GPIO_NUM-1:0] cio_gpio_i, cio_gpio_o, cio_gpio_en_o, intr_gpio_o;

  // Register model and expected responses, oldest first
  logic m_exit_valid = 1'b0;
  logic [31:0] m_exit_value = '0;
  logic [FAST_INTR_NUM-1:0] m_pending = '0, m_enable = '0;
  logic [GPIO_NUM-1:0] m_out = '0, m_en = '0, m_intr_en = '0;
  logic [32:0] exp_q [$];
  logic [32:0] exp_rsp;

  logic [31:0] lfsr = 32'd68728;
  logic [31:0] rnd_wd, rnd_addr;
  int n_checks = 0, n_errors = 0, n_tests = 0, err_mark = 0, total_err;

  ao_peripheral_subsystem DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    repeat (TOTAL_REQ * 4 + 200) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the run did not complete", TOTAL_REQ * 4 + 200);
    $display("TEST FAILED");
    $finish;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return r;
  endfunction

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, exp, act);
    end
  endtask

  // Drive one request and apply it to the model
  task automatic issue(input logic we, input logic [31:0] addr, input logic [31:0] wdata);
    logic [32:0] rsp;
    rsp = '0;
    bus_req_i   <= 1'b1;
    bus_we_i    <= we;
    bus_addr_i  <= addr;
    bus_wdata_i <= wdata;
    if (!(addr[31:12] inside {P_SOC, P_FIC, P_GPIO})) begin
      rsp[32] = 1'b1;
    end else if (we) begin
      case ({addr[31:2], 2'b00})
        A_EXIT_VALID: m_exit_valid = wdata[0];
        A_EXIT_VALUE: m_exit_value = wdata;
        A_PENDING:    m_pending = m_pending & ~wdata[FAST_INTR_NUM-1:0];
        A_ENABLE:     m_enable = wdata[FAST_INTR_NUM-1:0];
        A_GPIO_OUT:   m_out = wdata[GPIO_NUM-1:0];
        A_GPIO_EN:    m_en = wdata[GPIO_NUM-1:0];
        A_INTR_EN:    m_intr_en = wdata[GPIO_NUM-1:0];
        default: ;
      endcase
    end else begin
      case ({addr[31:2], 2'b00})
        A_EXIT_VALID: rsp[0] = m_exit_valid;
        A_EXIT_VALUE: rsp[31:0] = m_exit_value;
        A_BOOT_SEL:   rsp[0] = boot_select_i;
        A_PENDING:    rsp[FAST_INTR_NUM-1:0] = m_pending;
        A_ENABLE:     rsp[FAST_INTR_NUM-1:0] = m_enable;
        A_GPIO_OUT:   rsp[GPIO_NUM-1:0] = m_out;
        A_GPIO_EN:    rsp[GPIO_NUM-1:0] = m_en;
        A_GPIO_IN:    rsp[GPIO_NUM-1:0] = cio_gpio_i;
        A_INTR_EN:    rsp[GPIO_NUM-1:0] = m_intr_en;
        default: ;
      endcase
    end
    exp_q.push_back(rsp);
    @(posedge clk_i);
  endtask

  task automatic idle(input int n);
    bus_req_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic drain();
    int n;
    n = 0;
    bus_req_i <= 1'b0;
    while (exp_q.size() != 0 && n < 20) begin
      @(posedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      n_errors += exp_q.size();
      $display("Missing bus responses, %0d requests got no answer", exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic check_outputs();
    compare("exit_valid_o", m_exit_valid, exit_valid_o);
    compare("exit_value_o", m_exit_value, exit_value_o);
    compare("fast_intr_o", m_pending & m_enable, fast_intr_o);
    compare("cio_gpio_o", m_out, cio_gpio_o);
    compare("cio_gpio_en_o", m_en, cio_gpio_en_o);
    compare("intr_gpio_o", cio_gpio_i & m_intr_en, intr_gpio_o);
  endtask

  task automatic end_test(input string name);
    drain();
    check_outputs();
    n_tests++;
    $display("Test %0d %s finished with %0d errors", n_tests, name, n_errors - err_mark);
    err_mark = n_errors;
  endtask

  // Responses are compared in request order
  always @(posedge clk_i) begin
    if (rst_n_i && bus_rsp_valid_o) begin
      if (exp_q.size() == 0) begin
        n_errors++;
        $display("Unexpected bus response with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        compare("bus_rdata_o", exp_rsp[31:0], bus_rdata_o);
        compare("bus_error_o", exp_rsp[32], bus_error_o);
      end
    end
  end

  initial begin
    rst_n_i = 1'b0;
    bus_req_i = 1'b0;
    bus_we_i = 1'b0;
    bus_addr_i = '0;
    bus_wdata_i = '0;
    boot_select_i = 1'b0;
    fast_intr_i = '0;
    cio_gpio_i = '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    for (int i = 0; i < 9; i++) issue(1'b0, TARGETS[i], '0);
    end_test("reset values");

    for (int i = 0; i < 200; i++) begin
      rnd_addr = TARGETS[rand_bits(4) % 9];
      issue(rand_bits(1), rnd_addr, rand_bits(32));
    end
    end_test("back-to-back traffic");

    // Unmapped access, then a read to confirm nothing moved
    for (int i = 0; i < 20; i++) begin
      rnd_addr = rand_bits(32);
      if (rnd_addr[31:12] inside {P_SOC, P_FIC, P_GPIO}) rnd_addr[31] = 1'b1;
      issue(rand_bits(1), rnd_addr, rand_bits(32));
      issue(1'b0, TARGETS[rand_bits(4) % 9], '0);
    end
    end_test("unmapped pages");

    issue(1'b1, A_ENABLE, rand_bits(32));
    for (int i = 0; i < 8; i++) begin
      drain();
      check_outputs();
      rnd_wd = rand_bits(FAST_INTR_NUM);
      fast_intr_i <= rnd_wd[FAST_INTR_NUM-1:0];
      m_pending = m_pending | rnd_wd[FAST_INTR_NUM-1:0];
      @(posedge clk_i);
      fast_intr_i <= '0;
      idle(4);
      issue(1'b0, A_PENDING, '0);
      issue(1'b1, A_PENDING, rand_bits(32));
      issue(1'b0, A_PENDING, '0);
    end
    end_test("fast interrupts");

    for (int i = 0; i < 6; i++) begin
      drain();
      check_outputs();
      rnd_wd = rand_bits(GPIO_NUM + 1);
      cio_gpio_i <= rnd_wd[GPIO_NUM-1:0];
      boot_select_i <= rnd_wd[GPIO_NUM];
      idle(4);
      issue(1'b1, A_INTR_EN, rand_bits(32));
      issue(1'b0, A_GPIO_IN, '0);
      issue(1'b0, A_BOOT_SEL, '0);
    end
    end_test("gpio inputs and boot select");

    total_err = n_errors + DUT.timing_chk.fail_count;
    $display("Done: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             n_tests, n_checks, n_errors, DUT.timing_chk.fail_count);
    if (total_err == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

//--- flist.f
source/ao_periph_pkg.sv
source/ao_periph_decode.sv
source/soc_ctrl_regs.sv
source/fast_intr_ctrl.sv
source/gpio_ao.sv
source/ao_rsp_mux.sv
source/ao_peripheral_subsystem.sv
test/ao_periph_checker.sv
test/tb_ao_peripheral_subsystem.sv
